// File: common/dram_traffic_pkg.sv
package dram_traffic_pkg;

    // controller side
    localparam int BURST_ADDR_W = 24;
    localparam int DATA_W       = 128;

    // read request word fields
    localparam int PERIOD_W = 14;
    localparam int INSTR_W  = 2;
    localparam int REQ_W    = INSTR_W + PERIOD_W + BURST_ADDR_W;  // 40

    // response is the data word followed by the echoed request
    localparam int RESP_W = DATA_W + REQ_W;  // 168

    localparam int COUNT_W = 16;  // completion counter

    typedef struct packed {
        logic [INSTR_W-1:0]      instrument;
        logic [PERIOD_W-1:0]     period;
        logic [BURST_ADDR_W-1:0] addr;
    } read_req_t;

    // one request picked by decode, waiting for the strobe register
    typedef struct packed {
        logic                    is_write;
        logic                    last;      // last beat of the sample load
        logic [BURST_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]       data;
        read_req_t               req_word;  // zero for writes
    } mem_req_t;

    // what result needs to know about each issued request
    typedef struct packed {
        logic      is_write;
        logic      last;
        read_req_t req_word;
    } inflight_t;

endpackage

// File: common/mem_req_if.sv
`timescale 1ns/1ps

// selected memory request, decode -> execute
interface mem_req_if import dram_traffic_pkg::*; ();

    logic     req_valid;
    logic     req_ready;
    mem_req_t req;

    modport decode (
        output req_valid,
        output req,
        input  req_ready
    );

    modport execute (
        input  req_valid,
        input  req,
        output req_ready
    );

endinterface

// File: common/inflight_if.sv
`timescale 1ns/1ps

// issued-request records forward, credits back
interface inflight_if import dram_traffic_pkg::*; ();

    logic      push;           // one per issued request
    inflight_t record;
    logic      credit_return;  // one per retired request

    modport execute (
        output push,
        output record,
        input  credit_return
    );

    modport result (
        input  push,
        input  record,
        output credit_return
    );

endinterface

// File: traffic/request_decode.sv
`timescale 1ns/1ps

module request_decode import dram_traffic_pkg::*; (
    input  logic              clk_dram_ctrl,
    input  logic              rst_dram_ctrl,

    input  logic [DATA_W-1:0] i_write_data,
    input  logic              i_write_last,
    input  logic              i_write_valid,
    output logic              o_write_ready,

    input  logic [REQ_W-1:0]  i_read_req_data,
    input  logic              i_read_req_valid,
    output logic              o_read_req_ready,

    input  logic              i_load_complete,

    mem_req_if.decode         mem_req
);

    logic                    in_ready;
    logic                    write_take;
    logic                    read_take;
    logic                    write_closed;  // last beat already taken
    logic [BURST_ADDR_W-1:0] write_addr;
    read_req_t               rd_word;

    assign rd_word = i_read_req_data;

    // output register empty or draining this cycle
    assign in_ready = !mem_req.req_valid || mem_req.req_ready;

    assign o_write_ready    = in_ready && !i_load_complete && !write_closed;
    assign o_read_req_ready = in_ready && i_load_complete;

    assign write_take = i_write_valid && o_write_ready;
    assign read_take  = i_read_req_valid && o_read_req_ready;

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            mem_req.req_valid <= 1'b0;
            write_addr        <= '0;
            write_closed      <= 1'b0;
        end else begin
            if (write_take || read_take) begin
                mem_req.req_valid <= 1'b1;
            end else if (mem_req.req_ready) begin
                mem_req.req_valid <= 1'b0;
            end

            if (write_take) begin
                write_addr <= write_addr + 1'b1;  // beat i goes to burst i
                if (i_write_last) begin
                    write_closed <= 1'b1;  // sticky until reset
                end
            end
        end
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (write_take) begin
            mem_req.req <= '{is_write: 1'b1,
                             last:     i_write_last,
                             addr:     write_addr,
                             data:     i_write_data,
                             req_word: '0};
        end else if (read_take) begin
            // burst address straight from the request word
            mem_req.req <= '{is_write: 1'b0,
                             last:     1'b0,
                             addr:     rd_word.addr,
                             data:     '0,
                             req_word: rd_word};
        end
    end

    // execute must see a steady request until it takes it
    a_req_hold: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        mem_req.req_valid && !mem_req.req_ready |=>
            mem_req.req_valid && $stable(mem_req.req));

endmodule

// File: traffic/request_execute.sv
`timescale 1ns/1ps

module request_execute import dram_traffic_pkg::*; #(
    parameter int INFLIGHT_DEPTH = 4
) (
    input  logic                    clk_dram_ctrl,
    input  logic                    rst_dram_ctrl,

    // controller strobe side
    input  logic                    i_mem_busy,
    output logic                    o_mem_en,
    output logic [BURST_ADDR_W-1:0] o_mem_addr,
    output logic                    o_mem_write_enable,
    output logic [DATA_W-1:0]       o_mem_write_data,

    mem_req_if.execute              mem_req,
    inflight_if.execute             inflight
);

    localparam int CREDIT_W = $clog2(INFLIGHT_DEPTH + 1);

    logic [CREDIT_W-1:0] credits;
    logic [CREDIT_W-1:0] credits_next;
    logic                issue;
    logic                take;
    mem_req_t            held;  // request sitting on the strobe

    // controller takes the strobe when not stalling
    assign issue = o_mem_en && !i_mem_busy;

    // credits left after this cycle's issue and return
    assign credits_next = credits
                        + CREDIT_W'(inflight.credit_return)
                        - CREDIT_W'(issue);

    // strobe free or freeing up, and a credit left for the new request
    assign mem_req.req_ready = (!o_mem_en || issue) && (credits_next != '0);
    assign take = mem_req.req_valid && mem_req.req_ready;

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            o_mem_en <= 1'b0;
            credits  <= CREDIT_W'(INFLIGHT_DEPTH);
        end else begin
            credits <= credits_next;
            if (take) begin
                o_mem_en <= 1'b1;
            end else if (issue) begin
                o_mem_en <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (take) begin
            held <= mem_req.req;
        end
    end

    assign o_mem_addr         = held.addr;
    assign o_mem_write_enable = held.is_write;
    assign o_mem_write_data   = held.data;

    // record goes out on the issue cycle, in issue order
    assign inflight.push   = issue;
    assign inflight.record = '{is_write: held.is_write,
                               last:     held.last,
                               req_word: held.req_word};

    // wishbone stall rule
    a_stall_hold: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        o_mem_en && i_mem_busy |=>
            o_mem_en && $stable(o_mem_addr) && $stable(o_mem_write_data)
            && $stable(o_mem_write_enable));

    // result must never hand back more than was issued
    a_credit_bound: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        credits <= CREDIT_W'(INFLIGHT_DEPTH));

endmodule

// File: traffic/response_router.sv
`timescale 1ns/1ps

module response_router import dram_traffic_pkg::*; #(
    parameter int INFLIGHT_DEPTH = 4
) (
    input  logic               clk_dram_ctrl,
    input  logic               rst_dram_ctrl,

    input  logic               i_mem_complete,
    input  logic [DATA_W-1:0]  i_mem_resp_data,

    output logic [RESP_W-1:0]  o_read_data,
    output logic               o_read_data_valid,
    input  logic               i_read_data_ready,

    output logic               o_sample_load_complete,
    output logic [COUNT_W-1:0] o_complete_count,

    inflight_if.result         inflight
);

    localparam int PTR_W = $clog2(INFLIGHT_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    // issued requests, oldest at the read pointer
    inflight_t        rec_mem [INFLIGHT_DEPTH];
    logic [PTR_W-1:0] rec_wr_ptr;
    logic [PTR_W-1:0] rec_rd_ptr;
    logic [CNT_W-1:0] rec_count;
    inflight_t        rec_head;

    // read responses waiting for the consumer
    logic [RESP_W-1:0] resp_mem [INFLIGHT_DEPTH];
    logic [PTR_W-1:0]  resp_wr_ptr;
    logic [PTR_W-1:0]  resp_rd_ptr;
    logic [CNT_W-1:0]  resp_count;

    logic ack_write;
    logic ack_read;
    logic resp_pop;

    assign rec_head  = rec_mem[rec_rd_ptr];
    assign ack_write = i_mem_complete && rec_head.is_write;
    assign ack_read  = i_mem_complete && !rec_head.is_write;

    assign o_read_data       = resp_mem[resp_rd_ptr];
    assign o_read_data_valid = resp_count != '0;
    assign resp_pop          = o_read_data_valid && i_read_data_ready;

    // writes retire on ack, reads once they leave the buffer
    assign inflight.credit_return = ack_write || resp_pop;

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            rec_wr_ptr             <= '0;
            rec_rd_ptr             <= '0;
            rec_count              <= '0;
            resp_wr_ptr            <= '0;
            resp_rd_ptr            <= '0;
            resp_count             <= '0;
            o_sample_load_complete <= 1'b0;
            o_complete_count       <= '0;
        end else begin
            if (inflight.push) rec_wr_ptr <= rec_wr_ptr + 1'b1;
            if (i_mem_complete) rec_rd_ptr <= rec_rd_ptr + 1'b1;
            rec_count <= rec_count + CNT_W'(inflight.push) - CNT_W'(i_mem_complete);

            if (ack_read) resp_wr_ptr <= resp_wr_ptr + 1'b1;
            if (resp_pop) resp_rd_ptr <= resp_rd_ptr + 1'b1;
            resp_count <= resp_count + CNT_W'(ack_read) - CNT_W'(resp_pop);

            if (ack_write && rec_head.last) begin
                o_sample_load_complete <= 1'b1;  // held until reset
            end
            if (i_mem_complete) begin
                o_complete_count <= o_complete_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (inflight.push) begin
            rec_mem[rec_wr_ptr] <= inflight.record;
        end
        if (ack_read) begin
            resp_mem[resp_wr_ptr] <= {i_mem_resp_data, rec_head.req_word};
        end
    end

    // controller acks only what execute issued
    a_ack_has_record: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        i_mem_complete |-> rec_count != '0);

    // decode keeps reads behind the load, so at most one credit per cycle
    a_single_return: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        !(ack_write && resp_pop));

endmodule

// File: logic/dram_traffic_top.sv
`timescale 1ns/1ps

module dram_traffic_top import dram_traffic_pkg::*; #(
    parameter int INFLIGHT_DEPTH = 4  // power of two, 2 to 16
) (
    input  logic                    clk_dram_ctrl,
    input  logic                    rst_dram_ctrl,

    // sample load stream
    input  logic [DATA_W-1:0]       i_write_data,
    input  logic                    i_write_last,
    input  logic                    i_write_valid,
    output logic                    o_write_ready,

    // read request stream
    input  logic [REQ_W-1:0]        i_read_req_data,
    input  logic                    i_read_req_valid,
    output logic                    o_read_req_ready,

    // read response stream
    output logic [RESP_W-1:0]       o_read_data,
    output logic                    o_read_data_valid,
    input  logic                    i_read_data_ready,

    // DDR3 controller, wishbone style
    output logic [BURST_ADDR_W-1:0] o_mem_addr,
    output logic                    o_mem_en,
    output logic                    o_mem_write_enable,
    output logic [DATA_W-1:0]       o_mem_write_data,
    input  logic                    i_mem_busy,
    input  logic                    i_mem_complete,
    input  logic [DATA_W-1:0]       i_mem_resp_data,

    output logic                    o_sample_load_complete,
    output logic [COUNT_W-1:0]      o_complete_count
);

    mem_req_if  mem_req ();
    inflight_if inflight ();

    request_decode u_decode (
        .clk_dram_ctrl    (clk_dram_ctrl),
        .rst_dram_ctrl    (rst_dram_ctrl),
        .i_write_data     (i_write_data),
        .i_write_last     (i_write_last),
        .i_write_valid    (i_write_valid),
        .o_write_ready    (o_write_ready),
        .i_read_req_data  (i_read_req_data),
        .i_read_req_valid (i_read_req_valid),
        .o_read_req_ready (o_read_req_ready),
        .i_load_complete  (o_sample_load_complete),  // reads open after the load
        .mem_req          (mem_req.decode)
    );

    request_execute #(
        .INFLIGHT_DEPTH (INFLIGHT_DEPTH)
    ) u_execute (
        .clk_dram_ctrl      (clk_dram_ctrl),
        .rst_dram_ctrl      (rst_dram_ctrl),
        .i_mem_busy         (i_mem_busy),
        .o_mem_en           (o_mem_en),
        .o_mem_addr         (o_mem_addr),
        .o_mem_write_enable (o_mem_write_enable),
        .o_mem_write_data   (o_mem_write_data),
        .mem_req            (mem_req.execute),
        .inflight           (inflight.execute)
    );

    response_router #(
        .INFLIGHT_DEPTH (INFLIGHT_DEPTH)
    ) u_result (
        .clk_dram_ctrl          (clk_dram_ctrl),
        .rst_dram_ctrl          (rst_dram_ctrl),
        .i_mem_complete         (i_mem_complete),
        .i_mem_resp_data        (i_mem_resp_data),
        .o_read_data            (o_read_data),
        .o_read_data_valid      (o_read_data_valid),
        .i_read_data_ready      (i_read_data_ready),
        .o_sample_load_complete (o_sample_load_complete),
        .o_complete_count       (o_complete_count),
        .inflight               (inflight.result)
    );

endmodule

// File: tb/dram_model.sv
`timescale 1ns/1ps

// DDR3 controller stand-in with random stall and in-order ack 1 to 5 cycles after issue
module dram_model import dram_traffic_pkg::*; #(
    parameter int SEED = 32'h2a42
) (
    input  logic                    clk_dram_ctrl,
    input  logic                    rst_dram_ctrl,
    input  logic                    i_mem_en,
    input  logic [BURST_ADDR_W-1:0] i_mem_addr,
    input  logic                    i_mem_write_enable,
    input  logic [DATA_W-1:0]       i_mem_write_data,
    output logic                    o_mem_busy,
    output logic                    o_mem_complete,
    output logic [DATA_W-1:0]       o_mem_resp_data,
    output int                      o_issue_count,
    output int                      o_ack_count
);

    logic [DATA_W-1:0]       mem [256];  // indexed by low address bits
    logic [BURST_ADDR_W-1:0] addr_q [$];
    int                      due_q [$];  // cycle from which the ack may show
    int                      cycle;
    integer                  seed;
    logic                    issued;
    logic                    acked;

    initial begin
        seed            = SEED;
        cycle           = 0;
        o_mem_busy      = 1'b0;
        o_mem_complete  = 1'b0;
        o_mem_resp_data = '0;
        o_issue_count   = 0;
        o_ack_count     = 0;
    end

    always @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            addr_q.delete();
            due_q.delete();
            cycle = 0;
            #5;
            o_mem_busy     = 1'b0;
            o_mem_complete = 1'b0;
            o_issue_count  = 0;
            o_ack_count    = 0;
        end else begin
            cycle  = cycle + 1;
            issued = i_mem_en && !o_mem_busy;  // sampled before the edge updates
            acked  = o_mem_complete;
            if (acked) begin
                void'(addr_q.pop_front());
                void'(due_q.pop_front());
            end
            if (issued) begin
                if (i_mem_write_enable) begin
                    mem[i_mem_addr[7:0]] = i_mem_write_data;
                end
                addr_q.push_back(i_mem_addr);
                due_q.push_back(cycle + int'($unsigned($random(seed)) % 5));
            end
            #5;
            o_issue_count  = o_issue_count + int'(issued);
            o_ack_count    = o_ack_count + int'(acked);
            o_mem_busy     = ($random(seed) & 3) == 0;  // stall about one cycle in four
            o_mem_complete = (due_q.size() != 0) && (due_q[0] <= cycle);
            o_mem_resp_data = o_mem_complete ? mem[addr_q[0][7:0]] : '0;
        end
    end

endmodule

// File: tb/tb_dram_traffic.sv
`timescale 1ns/1ps

module tb_dram_traffic import dram_traffic_pkg::*; ();

    localparam int INFLIGHT_DEPTH = 4;
    localparam int LOAD_BEATS     = 12;
    localparam int READS_PER_RUN  = 40;
    localparam int WAIT_LIMIT     = 2000;  // cycles

    logic                    clk_dram_ctrl;
    logic                    rst_dram_ctrl;
    logic [DATA_W-1:0]       i_write_data;
    logic                    i_write_last;
    logic                    i_write_valid;
    logic                    o_write_ready;
    logic [REQ_W-1:0]        i_read_req_data;
    logic                    i_read_req_valid;
    logic                    o_read_req_ready;
    logic [RESP_W-1:0]       o_read_data;
    logic                    o_read_data_valid;
    logic                    i_read_data_ready;
    logic [BURST_ADDR_W-1:0] o_mem_addr;
    logic                    o_mem_en;
    logic                    o_mem_write_enable;
    logic [DATA_W-1:0]       o_mem_write_data;
    logic                    i_mem_busy;
    logic                    i_mem_complete;
    logic [DATA_W-1:0]       i_mem_resp_data;
    logic                    o_sample_load_complete;
    logic [COUNT_W-1:0]      o_complete_count;
    int                      issue_count;
    int                      ack_count;

    logic [DATA_W-1:0] loaded [LOAD_BEATS];  // own copy of the sample load
    logic [RESP_W-1:0] exp_q [$];
    integer            seed;
    int                errors;
    int                checked;
    int                writes_seen;
    int                acks_seen;
    logic              load_done_exp;
    logic              drain;

    dram_traffic_top #(.INFLIGHT_DEPTH(INFLIGHT_DEPTH)) DUT (.*);

    dram_model #(.SEED(32'h2a42)) u_model (
        .clk_dram_ctrl      (clk_dram_ctrl),
        .rst_dram_ctrl      (rst_dram_ctrl),
        .i_mem_en           (o_mem_en),
        .i_mem_addr         (o_mem_addr),
        .i_mem_write_enable (o_mem_write_enable),
        .i_mem_write_data   (o_mem_write_data),
        .o_mem_busy         (i_mem_busy),
        .o_mem_complete     (i_mem_complete),
        .o_mem_resp_data    (i_mem_resp_data),
        .o_issue_count      (issue_count),
        .o_ack_count        (ack_count)
    );

    initial begin
        clk_dram_ctrl = 1'b0;
        forever #50 clk_dram_ctrl = ~clk_dram_ctrl;
    end

    // stored word at the request's address, then the request word itself
    function automatic logic [RESP_W-1:0] expected_response(input logic [REQ_W-1:0] req);
        logic [BURST_ADDR_W-1:0] addr;
        addr = req[BURST_ADDR_W-1:0];  // address sits in the low field
        return {loaded[addr], req};
    endfunction

    task automatic compare_value(input string name, input logic [RESP_W-1:0] exp,
                                 input logic [RESP_W-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout: %s", what);
        $display("errors %0d, responses checked %0d", errors + 1, checked);
        $display("Checks failed");
        $finish;
    endtask

    task automatic send_beat(input logic [DATA_W-1:0] data, input logic last);
        int waited;
        waited        = 0;
        i_write_data  = data;
        i_write_last  = last;
        i_write_valid = 1'b1;
        @(posedge clk_dram_ctrl);
        while (!o_write_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) stop_on_timeout("write beat was never accepted");
            @(posedge clk_dram_ctrl);
        end
        #5;
        i_write_valid = 1'b0;
    endtask

    task automatic send_reads(input int count);
        read_req_t req;
        int        waited;
        repeat (count) begin
            req.instrument   = $random(seed);
            req.period       = $random(seed);
            req.addr         = $unsigned($random(seed)) % LOAD_BEATS;
            i_read_req_data  = req;
            i_read_req_valid = 1'b1;
            waited           = 0;
            @(posedge clk_dram_ctrl);
            while (!o_read_req_ready) begin
                waited++;
                if (waited > WAIT_LIMIT) stop_on_timeout("read request was never accepted");
                @(posedge clk_dram_ctrl);
            end
            #5;
            i_read_req_valid = 1'b0;
        end
    endtask

    // called 5 ns after an edge, returns the same way
    task automatic wait_for_load();
        int waited;
        waited = 0;
        while (!o_sample_load_complete) begin
            waited++;
            if (waited > WAIT_LIMIT) stop_on_timeout("sample load never completed");
            @(posedge clk_dram_ctrl);
            #5;
        end
    endtask

    task automatic wait_for_responses();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > WAIT_LIMIT) stop_on_timeout("read responses stopped arriving");
            @(posedge clk_dram_ctrl);
            #5;
        end
    endtask

    // short ready bursts, long low stretches
    task automatic toggle_read_ready();
        int len;
        while (!drain) begin
            i_read_data_ready = ~i_read_data_ready;
            if (i_read_data_ready) len = 1 + int'($unsigned($random(seed)) % 4);
            else len = 4 + int'($unsigned($random(seed)) % 16);
            repeat (len) begin
                @(posedge clk_dram_ctrl);
                #5;
            end
        end
        i_read_data_ready = 1'b1;
    endtask

    // controller port, load timing and outstanding bound
    always @(posedge clk_dram_ctrl) begin
        if (!rst_dram_ctrl) begin
            if (o_mem_en && !i_mem_busy && o_mem_write_enable) begin
                if (writes_seen < LOAD_BEATS) begin
                    compare_value("load write addr", writes_seen, o_mem_addr);
                    compare_value("load write data", loaded[writes_seen], o_mem_write_data);
                end else begin
                    errors++;
                    $display("a write was issued after the sample load had ended");
                end
                writes_seen++;
            end
            compare_value("load complete", load_done_exp, o_sample_load_complete);
            if (load_done_exp) compare_value("write ready after load", 0, o_write_ready);
            if (i_mem_complete) begin
                if (acks_seen == LOAD_BEATS - 1) load_done_exp = 1'b1;  // ack of the last beat
                acks_seen++;
            end
            if (issue_count - ack_count > INFLIGHT_DEPTH) begin
                errors++;
                $display("more requests outstanding at the controller than allowed");
            end
        end
    end

    always @(posedge clk_dram_ctrl) begin
        if (!rst_dram_ctrl && i_read_req_valid && o_read_req_ready) begin
            exp_q.push_back(expected_response(i_read_req_data));
        end
    end

    always @(posedge clk_dram_ctrl) begin
        if (!rst_dram_ctrl && o_read_data_valid && i_read_data_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("a read response came out with no request outstanding");
            end else begin
                compare_value("read response", exp_q.pop_front(), o_read_data);
                checked++;
            end
        end
    end

    initial begin
        seed              = 32'h2a42;
        errors            = 0;
        checked           = 0;
        writes_seen       = 0;
        acks_seen         = 0;
        load_done_exp     = 1'b0;
        drain             = 1'b0;
        rst_dram_ctrl     = 1'b1;
        i_write_data      = '0;
        i_write_last      = 1'b0;
        i_write_valid     = 1'b0;
        i_read_req_data   = '0;
        i_read_req_valid  = 1'b0;
        i_read_data_ready = 1'b1;
        repeat (16) @(posedge clk_dram_ctrl);
        #5;
        rst_dram_ctrl = 1'b0;

        @(posedge clk_dram_ctrl);
        compare_value("reset mem_en", 0, o_mem_en);
        compare_value("reset read_data_valid", 0, o_read_data_valid);
        compare_value("reset load_complete", 0, o_sample_load_complete);
        compare_value("reset read_req_ready", 0, o_read_req_ready);
        compare_value("reset write_ready", 1, o_write_ready);
        compare_value("reset complete_count", 0, o_complete_count);
        #5;

        for (int i = 0; i < LOAD_BEATS; i++) begin
            loaded[i] = {$random(seed), $random(seed), $random(seed), $random(seed)};
        end
        for (int i = 0; i < LOAD_BEATS; i++) begin
            send_beat(loaded[i], i == LOAD_BEATS - 1);
        end
        wait_for_load();

        send_reads(READS_PER_RUN);  // consumer always ready
        wait_for_responses();

        fork
            toggle_read_ready();
            begin
                send_reads(READS_PER_RUN);
                drain = 1'b1;
            end
        join
        wait_for_responses();

        @(posedge clk_dram_ctrl);
        compare_value("complete count", ack_count, o_complete_count);
        compare_value("load writes", LOAD_BEATS, writes_seen);
        compare_value("leftover response", 0, o_read_data_valid);  // nothing duplicated

        $display("errors %0d, responses checked %0d", errors, checked);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: project.f
common/dram_traffic_pkg.sv
common/mem_req_if.sv
common/inflight_if.sv
traffic/request_decode.sv
traffic/request_execute.sv
traffic/response_router.sv
logic/dram_traffic_top.sv
tb/dram_model.sv
tb/tb_dram_traffic.sv
